// File: logic/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cpu byte address split as tag, set, offset
`define CACHE_TAG_W 10
`define CACHE_SET_W 5
`define CACHE_OFF_W 4
`define CACHE_ADDR_W 19

// line geometry
`define CACHE_LINE_BYTES 16
`define CACHE_LINE_W (`CACHE_LINE_BYTES * 8)

// memory side line address is tag then set
`define CACHE_LINE_ADDR_W (`CACHE_TAG_W + `CACHE_SET_W)

// array organisation
`define CACHE_SETS 32
// replacement shifts way 0 into way 1, so the cache is fixed at two ways
`define CACHE_WAYS 2

// hit and miss counter width
`define CACHE_CNT_W 20

`endif

// File: logic/cache_pkg.sv
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    typedef logic [`CACHE_LINE_W-1:0] line_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    // cpu opcodes
    typedef enum logic [2:0] {
        NOP        = 3'b000,
        READ8      = 3'b001,
        READ16     = 3'b010,
        READ32     = 3'b011,
        INVALIDATE = 3'b100,
        WRITE8     = 3'b101,
        WRITE16    = 3'b110,
        WRITE32    = 3'b111
    } cpu_cmd_e;

    typedef enum logic [0:0] {
        READ_LINE  = 1'b0,
        WRITE_LINE = 1'b1
    } mem_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        FILL,
        FINISH
    } ctrl_state_e;

    typedef struct packed {
        logic                     valid;
        cpu_cmd_e                 cmd;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [31:0]              wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;
        logic        hit;
        logic [31:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic                          valid;
        mem_cmd_e                      cmd;
        logic [`CACHE_LINE_ADDR_W-1:0] line_addr;
        line_t                         line;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        line_t line;
    } mem_resp_t;

    // state of one way in the looked up set
    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_info_t;

    typedef struct packed {
        logic                              hit;
        logic                              hit_way;
        line_t                             hit_line;
        way_info_t [`CACHE_WAYS-1:0]       way;
    } lookup_t;

    // update commands for the line store, all act on the current set
    typedef struct packed {
        logic  fill;
        logic  shift;
        logic  write_way;
        line_t write_line;
        logic  invalidate;
        logic  way;
    } store_op_t;

endpackage

`default_nettype wire

// File: logic/byte_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module byte_lane
    import cache_pkg::*;
(
    input  line_t                   line,
    input  cpu_cmd_e                cmd,
    input  logic [`CACHE_OFF_W-1:0] offset,
    input  logic [31:0]             wdata,
    output logic [31:0]             rdata,
    output line_t                   merged
);

    // byte offset as a bit shift
    logic [`CACHE_OFF_W+2:0] shamt;
    line_t                   line_sh;
    logic [31:0]             wmask;
    line_t                   mask_sh;
    line_t                   wdata_sh;

    assign shamt   = {offset, 3'b000};
    assign line_sh = line >> shamt;

    // little-endian, upper bytes zero on short reads
    always_comb begin
        case (cmd)
            READ8:   rdata = {24'h0, line_sh[7:0]};
            READ16:  rdata = {16'h0, line_sh[15:0]};
            READ32:  rdata = line_sh[31:0];
            default: rdata = 32'h0;
        endcase
    end

    always_comb begin
        case (cmd)
            WRITE8:  wmask = 32'h0000_00ff;
            WRITE16: wmask = 32'h0000_ffff;
            WRITE32: wmask = 32'hffff_ffff;
            default: wmask = 32'h0;
        endcase
    end

    assign mask_sh  = line_t'(wmask) << shamt;
    assign wdata_sh = line_t'(wdata) << shamt;
    assign merged   = (line & ~mask_sh) | (wdata_sh & mask_sh);

endmodule

`default_nettype wire

// File: logic/line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module line_store
    import cache_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic [`CACHE_SET_W-1:0] store_set,
    input  tag_t                    store_tag,
    input  store_op_t               store_op,
    output lookup_t                 lookup
);

    // status bits per set, bit index is the way
    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
    tag_t                   tag_q   [`CACHE_SETS][`CACHE_WAYS];
    line_t                  data_q  [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] match;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w]            = valid_q[store_set][w] && (tag_q[store_set][w] == store_tag);
            lookup.way[w].valid = valid_q[store_set][w];
            lookup.way[w].dirty = dirty_q[store_set][w];
            lookup.way[w].tag   = tag_q[store_set][w];
            lookup.way[w].line  = data_q[store_set][w];
        end
        // a tag lives in at most one way, so way 1 matching decides the way
        lookup.hit      = |match;
        lookup.hit_way  = match[1];
        lookup.hit_line = data_q[store_set][match[1]];
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            // invalidate drops the line and any dirty data with it
            if (store_op.invalidate) begin
                valid_q[store_set] <= valid_q[store_set] & ~match;
                dirty_q[store_set] <= dirty_q[store_set] & ~match;
            end
            if (store_op.shift) begin
                valid_q[store_set][1] <= valid_q[store_set][0];
                dirty_q[store_set][1] <= dirty_q[store_set][0];
            end
            if (store_op.fill) begin
                valid_q[store_set][0] <= 1'b1;
                dirty_q[store_set][0] <= 1'b0;
            end
            if (store_op.write_way) begin
                dirty_q[store_set][store_op.way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (store_op.shift) begin
            tag_q[store_set][1]  <= tag_q[store_set][0];
            data_q[store_set][1] <= data_q[store_set][0];
        end
        if (store_op.fill) begin
            tag_q[store_set][0]  <= store_tag;
            data_q[store_set][0] <= store_op.write_line;
        end
        if (store_op.write_way) begin
            data_q[store_set][store_op.way] <= store_op.write_line;
        end
    end

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  cpu_req_t                cpu_req,
    output logic                    ready,
    output cpu_resp_t               cpu_resp,
    output mem_req_t                mem_req,
    input  mem_resp_t               mem_resp,
    output logic [`CACHE_CNT_W-1:0] hit_count,
    output logic [`CACHE_CNT_W-1:0] miss_count,
    output logic [`CACHE_SET_W-1:0] store_set,
    output tag_t                    store_tag,
    input  lookup_t                 lookup,
    output store_op_t               store_op,
    output line_t                   lane_line,
    output cpu_cmd_e                lane_cmd,
    output logic [`CACHE_OFF_W-1:0] lane_off,
    output logic [31:0]             lane_wdata,
    input  logic [31:0]             lane_rdata,
    input  line_t                   lane_merged
);

    ctrl_state_e state;
    cpu_req_t    req_q;
    // set once this access has missed, so the replay lookup is not counted
    logic        missed;
    logic        is_read;
    logic        is_write;
    logic        is_access;
    logic        wb_needed;

    assign is_read   = req_q.cmd inside {READ8, READ16, READ32};
    assign is_write  = req_q.cmd inside {WRITE8, WRITE16, WRITE32};
    assign is_access = is_read | is_write;

    // way 1 is the victim and goes to memory only if valid and dirty
    assign wb_needed = lookup.way[1].valid & lookup.way[1].dirty;

    assign ready = (state == IDLE);

    assign store_tag  = req_q.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign store_set  = req_q.addr[`CACHE_OFF_W +: `CACHE_SET_W];
    assign lane_off   = req_q.addr[`CACHE_OFF_W-1:0];
    assign lane_cmd   = req_q.cmd;
    assign lane_wdata = req_q.wdata;
    assign lane_line  = lookup.hit_line;

    always_comb begin
        store_op = '0;
        case (state)
            LOOKUP: begin
                if (req_q.cmd == INVALIDATE) begin
                    store_op.invalidate = 1'b1;
                end else if (is_write && lookup.hit) begin
                    store_op.write_way  = 1'b1;
                    store_op.way        = lookup.hit_way;
                    store_op.write_line = lane_merged;
                end
            end
            FILL: begin
                // old way 0 moves to way 1 in the same edge as the new line lands
                if (mem_resp.valid) begin
                    store_op.shift      = 1'b1;
                    store_op.fill       = 1'b1;
                    store_op.write_line = mem_resp.line;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state          <= IDLE;
            missed         <= 1'b0;
            cpu_resp.valid <= 1'b0;
            mem_req.valid  <= 1'b0;
            hit_count      <= '0;
            miss_count     <= '0;
        end else begin
            cpu_resp.valid <= 1'b0;
            mem_req.valid  <= 1'b0;
            case (state)
                IDLE: begin
                    if (cpu_req.valid) begin
                        req_q  <= cpu_req;
                        missed <= 1'b0;
                        state  <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (!is_access || lookup.hit) begin
                        cpu_resp.valid <= 1'b1;
                        cpu_resp.hit   <= is_access & ~missed;
                        // byte_lane gives zero for anything but a read
                        cpu_resp.rdata <= lane_rdata;
                        if (is_access && !missed) begin
                            hit_count <= hit_count + 1'b1;
                        end
                        state <= FINISH;
                    end else begin
                        missed        <= 1'b1;
                        miss_count    <= miss_count + 1'b1;
                        mem_req.valid <= 1'b1;
                        mem_req.line  <= lookup.way[1].line;
                        if (wb_needed) begin
                            mem_req.cmd       <= WRITE_LINE;
                            mem_req.line_addr <= {lookup.way[1].tag, store_set};
                            state             <= WRITE_BACK;
                        end else begin
                            mem_req.cmd       <= READ_LINE;
                            mem_req.line_addr <= {store_tag, store_set};
                            state             <= FILL;
                        end
                    end
                end
                WRITE_BACK: begin
                    if (mem_resp.valid) begin
                        mem_req.valid     <= 1'b1;
                        mem_req.cmd       <= READ_LINE;
                        mem_req.line_addr <= {store_tag, store_set};
                        state             <= FILL;
                    end
                end
                FILL: begin
                    // replay the lookup, which now hits in way 0
                    if (mem_resp.valid) begin
                        state <= LOOKUP;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  cpu_req_t                cpu_req,
    output logic                    ready,
    output cpu_resp_t               cpu_resp,
    output mem_req_t                mem_req,
    input  mem_resp_t               mem_resp,
    output logic [`CACHE_CNT_W-1:0] hit_count,
    output logic [`CACHE_CNT_W-1:0] miss_count
);

    logic [`CACHE_SET_W-1:0] store_set;
    tag_t                    store_tag;
    store_op_t               store_op;
    lookup_t                 lookup;
    line_t                   lane_line;
    line_t                   lane_merged;
    cpu_cmd_e                lane_cmd;
    logic [`CACHE_OFF_W-1:0] lane_off;
    logic [31:0]             lane_wdata;
    logic [31:0]             lane_rdata;

    cache_ctrl u_ctrl (
        .CLK         (CLK),
        .RESET       (RESET),
        .cpu_req     (cpu_req),
        .ready       (ready),
        .cpu_resp    (cpu_resp),
        .mem_req     (mem_req),
        .mem_resp    (mem_resp),
        .hit_count   (hit_count),
        .miss_count  (miss_count),
        .store_set   (store_set),
        .store_tag   (store_tag),
        .lookup      (lookup),
        .store_op    (store_op),
        .lane_line   (lane_line),
        .lane_cmd    (lane_cmd),
        .lane_off    (lane_off),
        .lane_wdata  (lane_wdata),
        .lane_rdata  (lane_rdata),
        .lane_merged (lane_merged)
    );

    line_store u_store (
        .CLK       (CLK),
        .RESET     (RESET),
        .store_set (store_set),
        .store_tag (store_tag),
        .store_op  (store_op),
        .lookup    (lookup)
    );

    byte_lane u_lane (
        .line   (lane_line),
        .cmd    (lane_cmd),
        .offset (lane_off),
        .wdata  (lane_wdata),
        .rdata  (lane_rdata),
        .merged (lane_merged)
    );

endmodule

`default_nettype wire

// File: tb/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module mem_model
    import cache_pkg::*;
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  mem_req_t                      mem_req,
    output mem_resp_t                     mem_resp,
    output logic [`CACHE_LINE_ADDR_W-1:0] wb_addr,
    output line_t                         wb_line,
    output int                            wb_count
);

    // only lines that were written back are stored, the rest follow the fill rule
    line_t  store_q [int];
    integer seed;
    logic   pending;
    int     wait_left;
    line_t  resp_line;

    // byte i of line L is the low byte of L*16+i, folded with the upper address bits
    function automatic line_t pattern_line(input logic [`CACHE_LINE_ADDR_W-1:0] la);
        line_t                    l;
        logic [`CACHE_ADDR_W-1:0] a;
        for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
            a = {la, i[`CACHE_OFF_W-1:0]};
            l[i*8 +: 8] = a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]};
        end
        return l;
    endfunction

    function automatic line_t read_line(input logic [`CACHE_LINE_ADDR_W-1:0] la);
        if (store_q.exists(int'(la))) begin
            return store_q[int'(la)];
        end
        return pattern_line(la);
    endfunction

    initial begin
        seed      = 69354;
        pending   = 1'b0;
        wait_left = 0;
        resp_line = '0;
        mem_resp  = '0;
        wb_addr   = '0;
        wb_line   = '0;
        wb_count  = 0;
    end

    // responses change on the falling edge, the cache samples them on the rising edge
    always @(negedge CLK) begin
        mem_resp.valid <= 1'b0;
        if (RESET) begin
            pending <= 1'b0;
        end else if (pending) begin
            if (wait_left <= 1) begin
                mem_resp.valid <= 1'b1;
                mem_resp.line  <= resp_line;
                pending        <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end else if (mem_req.valid) begin
            pending   <= 1'b1;
            wait_left <= 1 + int'($unsigned($random(seed)) % 8);
            if (mem_req.cmd == WRITE_LINE) begin
                store_q[int'(mem_req.line_addr)] = mem_req.line;
                wb_addr   <= mem_req.line_addr;
                wb_line   <= mem_req.line;
                wb_count  <= wb_count + 1;
                resp_line <= '0;
                $display("mem_model: write-back to line %h data %h",
                         mem_req.line_addr, mem_req.line);
            end else begin
                resp_line <= read_line(mem_req.line_addr);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_tb
    import cache_pkg::*;
();

    // room for 64 accesses of up to 40 cycles each
    localparam int TIMEOUT_CYCLES = 64 * 40;

    logic                          CLK = 1'b0;
    logic                          RESET;
    cpu_req_t                      cpu_req;
    logic                          ready;
    cpu_resp_t                     cpu_resp;
    mem_req_t                      mem_req;
    mem_resp_t                     mem_resp;
    logic [`CACHE_CNT_W-1:0]       hit_count;
    logic [`CACHE_CNT_W-1:0]       miss_count;
    logic [`CACHE_LINE_ADDR_W-1:0] wb_addr;
    line_t                         wb_line;
    int                            wb_count;

    // reference model of tags, dirty bits, lines and memory
    logic                    ref_valid [`CACHE_SETS][`CACHE_WAYS];
    logic                    ref_dirty [`CACHE_SETS][`CACHE_WAYS];
    tag_t                    ref_tag   [`CACHE_SETS][`CACHE_WAYS];
    line_t                   ref_line  [`CACHE_SETS][`CACHE_WAYS];
    line_t                   ref_mem   [int];
    logic [`CACHE_CNT_W-1:0] ref_hits;
    logic [`CACHE_CNT_W-1:0] ref_misses;
    int                      cycle_count = 0;
    integer                  seed;

    always #2 CLK = ~CLK;

    cache_top u_dut (
        .CLK        (CLK),
        .RESET      (RESET),
        .cpu_req    (cpu_req),
        .ready      (ready),
        .cpu_resp   (cpu_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    mem_model u_mem (
        .CLK      (CLK),
        .RESET    (RESET),
        .mem_req  (mem_req),
        .mem_resp (mem_resp),
        .wb_addr  (wb_addr),
        .wb_line  (wb_line),
        .wb_count (wb_count)
    );

    task automatic end_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_count(input string name, input logic [`CACHE_CNT_W-1:0] exp,
                               input logic [`CACHE_CNT_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input logic [`CACHE_LINE_ADDR_W-1:0] exp,
                              input logic [`CACHE_LINE_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    // byte i of line L comes from L*16+i with the upper address bits folded in
    function automatic line_t mem_rule_line(input logic [`CACHE_LINE_ADDR_W-1:0] la);
        line_t                    l;
        logic [`CACHE_ADDR_W-1:0] a;
        for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
            a = {la, i[`CACHE_OFF_W-1:0]};
            l[i*8 +: 8] = a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]};
        end
        return l;
    endfunction

    function automatic line_t ref_mem_read(input logic [`CACHE_LINE_ADDR_W-1:0] la);
        if (ref_mem.exists(int'(la))) begin
            return ref_mem[int'(la)];
        end
        return mem_rule_line(la);
    endfunction

    function automatic int access_size(input cpu_cmd_e cmd);
        case (cmd)
            READ8, WRITE8:   return 1;
            READ16, WRITE16: return 2;
            default:         return 4;
        endcase
    endfunction

    function automatic logic [`CACHE_ADDR_W-1:0] make_addr(input tag_t tag,
            input logic [`CACHE_SET_W-1:0] set, input logic [`CACHE_OFF_W-1:0] off);
        return {tag, set, off};
    endfunction

    // predicts one access and updates the model as the cache should
    task automatic model_access(input cpu_cmd_e cmd, input logic [`CACHE_ADDR_W-1:0] addr,
            input logic [31:0] wdata, output logic exp_hit, output logic [31:0] exp_data,
            output logic exp_wb, output logic [`CACHE_LINE_ADDR_W-1:0] exp_wb_addr,
            output line_t exp_wb_line);
        logic [`CACHE_SET_W-1:0] set;
        tag_t                    tag;
        int                      off;
        int                      way;
        set         = addr[`CACHE_OFF_W +: `CACHE_SET_W];
        tag         = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        off         = int'(addr[`CACHE_OFF_W-1:0]);
        exp_hit     = 1'b0;
        exp_data    = '0;
        exp_wb      = 1'b0;
        exp_wb_addr = '0;
        exp_wb_line = '0;
        way         = -1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                way = w;
            end
        end
        if (cmd == INVALIDATE) begin
            // dirty data is dropped, memory keeps its old line
            if (way >= 0) begin
                ref_valid[set][way] = 1'b0;
                ref_dirty[set][way] = 1'b0;
            end
        end else begin
            if (way >= 0) begin
                exp_hit  = 1'b1;
                ref_hits = ref_hits + 1'b1;
            end else begin
                ref_misses = ref_misses + 1'b1;
                if (ref_valid[set][1] && ref_dirty[set][1]) begin
                    exp_wb      = 1'b1;
                    exp_wb_addr = {ref_tag[set][1], set};
                    exp_wb_line = ref_line[set][1];
                    ref_mem[int'(exp_wb_addr)] = exp_wb_line;
                end
                ref_valid[set][1] = ref_valid[set][0];
                ref_dirty[set][1] = ref_dirty[set][0];
                ref_tag[set][1]   = ref_tag[set][0];
                ref_line[set][1]  = ref_line[set][0];
                ref_valid[set][0] = 1'b1;
                ref_dirty[set][0] = 1'b0;
                ref_tag[set][0]   = tag;
                ref_line[set][0]  = ref_mem_read({tag, set});
                way = 0;
            end
            for (int b = 0; b < access_size(cmd); b++) begin
                if (cmd inside {READ8, READ16, READ32}) begin
                    exp_data[b*8 +: 8] = ref_line[set][way][(off+b)*8 +: 8];
                end else begin
                    ref_line[set][way][(off+b)*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            if (cmd inside {WRITE8, WRITE16, WRITE32}) begin
                ref_dirty[set][way] = 1'b1;
            end
        end
    endtask

    // issues one request on a falling edge and checks everything it produces
    task automatic do_access(input cpu_cmd_e cmd, input logic [`CACHE_ADDR_W-1:0] addr,
                             input logic [31:0] wdata);
        logic                          exp_hit;
        logic [31:0]                   exp_data;
        logic                          exp_wb;
        logic [`CACHE_LINE_ADDR_W-1:0] exp_wb_addr;
        line_t                         exp_wb_line;
        int                            wb_before;
        int                            cycles;
        model_access(cmd, addr, wdata, exp_hit, exp_data, exp_wb, exp_wb_addr, exp_wb_line);
        wb_before = wb_count;
        while (!ready) begin
            @(negedge CLK);
        end
        cpu_req.valid = 1'b1;
        cpu_req.cmd   = cmd;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        @(negedge CLK);
        cpu_req = '0;
        cycles  = 1;
        check_hit("ready", 1'b0, ready);
        while (!cpu_resp.valid) begin
            @(negedge CLK);
            cycles++;
        end
        check_hit("cpu_resp.hit", exp_hit, cpu_resp.hit);
        check_data("cpu_resp.rdata", exp_data, cpu_resp.rdata);
        if ((exp_hit || cmd == INVALIDATE) && cycles != 2) begin
            $display("[FAIL] %0t response latency expected 2 got %0d", $time, cycles);
            end_with_failure();
        end
        if (wb_count - wb_before != (exp_wb ? 1 : 0)) begin
            $display("[FAIL] %0t write-back count expected %0d got %0d", $time,
                     exp_wb ? 1 : 0, wb_count - wb_before);
            end_with_failure();
        end
        if (exp_wb) begin
            check_addr("mem_req.line_addr", exp_wb_addr, wb_addr);
            check_line("mem_req.line", exp_wb_line, wb_line);
        end
        @(negedge CLK);
        // the response is a single cycle pulse
        check_hit("cpu_resp.valid", 1'b0, cpu_resp.valid);
        check_hit("ready", 1'b1, ready);
        check_count("hit_count", ref_hits, hit_count);
        check_count("miss_count", ref_misses, miss_count);
    endtask

    task automatic test_after_reset();
        check_hit("ready", 1'b1, ready);
        check_hit("cpu_resp.valid", 1'b0, cpu_resp.valid);
        check_hit("mem_req.valid", 1'b0, mem_req.valid);
        check_count("hit_count", '0, hit_count);
        check_count("miss_count", '0, miss_count);
        do_access(READ32, make_addr(10'h011, 5'd3, 4'd0), 32'h0);
    endtask

    task automatic test_read_hits();
        do_access(READ8, make_addr(10'h011, 5'd3, 4'd3), 32'h0);
        do_access(READ16, make_addr(10'h011, 5'd3, 4'd6), 32'h0);
        do_access(READ32, make_addr(10'h011, 5'd3, 4'd12), 32'h0);
        do_access(READ8, make_addr(10'h011, 5'd3, 4'd15), 32'h0);
        do_access(READ16, make_addr(10'h011, 5'd3, 4'd0), 32'h0);
    endtask

    task automatic test_writes();
        do_access(WRITE8, make_addr(10'h011, 5'd3, 4'd5), 32'h1234_56a5);
        do_access(READ32, make_addr(10'h011, 5'd3, 4'd4), 32'h0);
        do_access(WRITE16, make_addr(10'h022, 5'd9, 4'd6), 32'h5555_beef);
        do_access(READ16, make_addr(10'h022, 5'd9, 4'd6), 32'h0);
        do_access(READ32, make_addr(10'h022, 5'd9, 4'd4), 32'h0);
        do_access(WRITE32, make_addr(10'h033, 5'd10, 4'd8), 32'hdead_0123);
        do_access(WRITE16, make_addr(10'h033, 5'd10, 4'd10), 32'h0000_7e7e);
        do_access(READ32, make_addr(10'h033, 5'd10, 4'd8), 32'h0);
        do_access(READ8, make_addr(10'h033, 5'd10, 4'd11), 32'h0);
    endtask

    // first tag is dirty and leaves only from way 1, later victims are clean
    task automatic test_eviction();
        do_access(WRITE32, make_addr(10'h101, 5'd7, 4'd0), 32'h1234_5678);
        do_access(READ32, make_addr(10'h202, 5'd7, 4'd4), 32'h0);
        do_access(READ32, make_addr(10'h303, 5'd7, 4'd8), 32'h0);
        do_access(READ32, make_addr(10'h104, 5'd7, 4'd0), 32'h0);
        do_access(READ32, make_addr(10'h101, 5'd7, 4'd0), 32'h0);
    endtask

    task automatic test_invalidate();
        do_access(WRITE32, make_addr(10'h155, 5'd12, 4'd4), 32'hcafe_f00d);
        do_access(INVALIDATE, make_addr(10'h155, 5'd12, 4'd0), 32'h0);
        do_access(READ32, make_addr(10'h155, 5'd12, 4'd4), 32'h0);
        do_access(INVALIDATE, make_addr(10'h2aa, 5'd12, 4'd0), 32'h0);
    endtask

    // short random mix over four tags in two sets, aligned to the access size
    task automatic test_random();
        logic [31:0]             r;
        cpu_cmd_e                cmd;
        tag_t                    tag;
        logic [`CACHE_SET_W-1:0] set;
        logic [`CACHE_OFF_W-1:0] off;
        for (int n = 0; n < 30; n++) begin
            r   = $random(seed);
            cmd = cpu_cmd_e'(3'(r % 7) + 3'd1);
            r   = $random(seed);
            tag = 10'h040 + 10'(r % 4);
            set = 5'd20 + 5'(r[8] ? 1 : 0);
            off = r[15:12];
            if (access_size(cmd) == 2) begin
                off[0] = 1'b0;
            end else if (access_size(cmd) == 4) begin
                off[1:0] = 2'b00;
            end
            r = $random(seed);
            do_access(cmd, make_addr(tag, set, off), r);
        end
    endtask

    // counters must hold their totals while the cache sits idle
    task automatic test_counters();
        repeat (4) @(negedge CLK);
        check_hit("cpu_resp.valid", 1'b0, cpu_resp.valid);
        check_count("hit_count", ref_hits, hit_count);
        check_count("miss_count", ref_misses, miss_count);
    endtask

    initial begin
        seed       = 69354;
        RESET      = 1'b1;
        cpu_req    = '0;
        ref_hits   = '0;
        ref_misses = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (5) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        test_after_reset();
        test_read_hits();
        test_writes();
        test_eviction();
        test_invalidate();
        test_random();
        test_counters();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/cache_pkg.sv
logic/byte_lane.sv
logic/line_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module cache_tb -f compile.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
